// ==== c64_loader_top.f ====
logic/c64_loader_pkg.sv
logic/download_decoder.sv
logic/basic_ptr_init.sv
logic/io_slot_writer.sv
logic/c64_loader_top.sv
dv/tb_clock_gen.sv
dv/c64_loader_tb.sv

// ==== dv/c64_loader_tb.sv ====
// Random testbench for the C64 media loader
// Sends PRG and TAP downloads and checks memory writes and the start strobe
`timescale 1ns/1ps
`default_nettype none

module c64_loader_tb;

	localparam logic [24:0] TAP_BASE   = 25'h200000;
	localparam logic [7:0]  TB_IDX_PRG = 8'h04;
	localparam logic [7:0]  TB_IDX_TAP = 8'h06;
	localparam int NUM_ROUNDS = 4;
	localparam int MAX_LEN    = 40;
	localparam int PTR_WRITES = 12;
	// Worst case bytes plus the page zero walk at 10 cycles per slot and doubled
	localparam int MAX_BYTES      = NUM_ROUNDS * (2 + 2 * MAX_LEN);
	localparam int TIMEOUT_CYCLES = (MAX_BYTES + 256 * NUM_ROUNDS) * 10 * 2;
	// Full page zero walk with every pointer write at the slowest slot spacing
	localparam int WALK_CYCLES    = 256 + PTR_WRITES * 10 * 2;

	wire         clk_sys;
	wire         reset_n;
	logic        ioctl_download_i;
	logic [7:0]  ioctl_index_i;
	logic        ioctl_wr_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0]  ioctl_data_i;
	logic        io_cycle_i;
	logic        ioctl_wait_o;
	logic        mem_we_o;
	logic [24:0] mem_addr_o;
	logic [7:0]  mem_data_o;
	logic        start_o;

	integer seed    = 32'h5a1e;
	integer io_seed = 32'h5a1e;
	int     io_min  = 1;
	int     io_max  = 4;
	logic   io_enable = 1'b0;

	// Memory model filled from the DUT write port
	logic [7:0] mem_data [int];
	int         wr_seq [int];
	int         wr_count    = 0;
	int         start_count = 0;
	int         start_wr    = 0;
	logic       we_prev     = 1'b0;
	int         cycle_count = 0;

	tb_clock_gen clock_gen_i (
		.clk_sys_o(clk_sys),
		.reset_n_o(reset_n)
	);

	c64_loader_top #(
		.TAP_BASE(TAP_BASE)
	) c64_loader_top_i (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.ioctl_download_i(ioctl_download_i),
		.ioctl_index_i(ioctl_index_i),
		.ioctl_wr_i(ioctl_wr_i),
		.ioctl_addr_i(ioctl_addr_i),
		.ioctl_data_i(ioctl_data_i),
		.io_cycle_i(io_cycle_i),
		.ioctl_wait_o(ioctl_wait_o),
		.mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o),
		.start_o(start_o)
	);

	function automatic int rand_range(inout integer s, input int lo, input int hi);
		int span;
		span = hi - lo + 1;
		return lo + int'($unsigned($random(s)) % $unsigned(span));
	endfunction

	// Byte a BASIC LOAD leaves at a page zero address or -1 where nothing is written
	function automatic int ptr_expected(input int addr, input int end_addr);
		case (addr)
			'h2B: return 'h01;
			'h2C: return 'h08;
			'hAC, 'hAD: return 0;
			'h2D, 'h2F, 'h31, 'hAE: return end_addr & 'hFF;
			'h2E, 'h30, 'h32, 'hAF: return (end_addr >> 8) & 'hFF;
			default: return -1;
		endcase
	endfunction

	function automatic int written_since(input int addr, input int base);
		if (!wr_seq.exists(addr))
			return 0;
		return (wr_seq[addr] >= base) ? 1 : 0;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// ========================================
	// Host side driver
	// ========================================

	// Wait level low for two sampled cycles in a row
	task automatic wait_host_ready();
		int low_run;
		low_run = 0;
		while (low_run < 2) begin
			@(negedge clk_sys);
			low_run = ioctl_wait_o ? 0 : low_run + 1;
		end
	endtask

	task automatic send_byte(input int addr, input logic [7:0] data);
		int gap;
		wait_host_ready();
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= 25'(addr);
		ioctl_data_i <= data;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		// Leaves time for the wait level to show up
		gap = rand_range(seed, 3, 5);
		repeat (gap) @(posedge clk_sys);
	endtask

	task automatic open_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_index_i    <= index;
		ioctl_download_i <= 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic close_download();
		wait_host_ready();
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// ========================================
	// Download rounds
	// ========================================

	task automatic run_prg(input int round);
		logic [7:0] data_q [$];
		int n;
		int load;
		int prg_end;
		int base_wr;
		int base_start;
		int exp;
		int i;
		n       = rand_range(seed, 1, MAX_LEN);
		load    = rand_range(seed, 'h0801, 'hE800);
		prg_end = (load + n) & 'hFFFF;
		for (i = 0; i < n; i++)
			data_q.push_back(8'(rand_range(seed, 0, 255)));
		@(posedge clk_sys);
		base_wr    = wr_count;
		base_start = start_count;
		open_download(TB_IDX_PRG);
		send_byte(0, 8'(load));
		send_byte(1, 8'(load >> 8));
		for (i = 0; i < n; i++)
			send_byte(i + 2, data_q[i]);
		close_download();
		while (start_count == base_start)
			@(posedge clk_sys);
		repeat (20) @(posedge clk_sys);
		for (i = 0; i < n; i++) begin
			check_value($sformatf("prg %0d byte %0d written", round, i), 1,
				written_since(load + i, base_wr));
			check_value($sformatf("prg %0d byte %0d", round, i), int'(data_q[i]),
				int'(mem_data[load + i]));
		end
		for (i = 0; i < 256; i++) begin
			exp = ptr_expected(i, prg_end);
			check_value($sformatf("prg %0d page zero %0h written", round, i),
				(exp < 0) ? 0 : 1, written_since(i, base_wr));
			if (exp >= 0)
				check_value($sformatf("prg %0d pointer %0h", round, i), exp,
					int'(mem_data[i]));
		end
		check_value($sformatf("prg %0d write count", round), n + PTR_WRITES,
			wr_count - base_wr);
		check_value($sformatf("prg %0d writes before start", round), n + PTR_WRITES,
			start_wr - base_wr);
		check_value($sformatf("prg %0d start pulses", round), 1, start_count - base_start);
	endtask

	task automatic run_tap(input int round);
		logic [7:0] data_q [$];
		int n;
		int base_wr;
		int base_start;
		int i;
		n = rand_range(seed, 1, MAX_LEN);
		for (i = 0; i < n; i++)
			data_q.push_back(8'(rand_range(seed, 0, 255)));
		@(posedge clk_sys);
		base_wr    = wr_count;
		base_start = start_count;
		open_download(TB_IDX_TAP);
		for (i = 0; i < n; i++)
			send_byte(i, data_q[i]);
		close_download();
		// Long enough for a whole pointer walk and its start pulse to show up
		repeat (WALK_CYCLES) @(posedge clk_sys);
		for (i = 0; i < n; i++) begin
			check_value($sformatf("tap %0d byte %0d written", round, i), 1,
				written_since(int'(TAP_BASE) + i, base_wr));
			check_value($sformatf("tap %0d byte %0d", round, i), int'(data_q[i]),
				int'(mem_data[int'(TAP_BASE) + i]));
		end
		check_value($sformatf("tap %0d write count", round), n, wr_count - base_wr);
		check_value($sformatf("tap %0d start pulses", round), 0, start_count - base_start);
	endtask

	// ========================================
	// Processes
	// ========================================

	// Memory I/O cycle with random level lengths
	initial begin
		int len;
		io_cycle_i <= 1'b0;
		wait (io_enable);
		forever begin
			len = rand_range(io_seed, io_min, io_max);
			repeat (len) @(posedge clk_sys);
			io_cycle_i <= !io_cycle_i;
		end
	end

	// One byte per rise of the write enable
	always @(negedge clk_sys) begin
		if (reset_n && mem_we_o && !we_prev) begin
			mem_data[int'(mem_addr_o)] = mem_data_o;
			wr_seq[int'(mem_addr_o)]   = wr_count;
			wr_count = wr_count + 1;
		end
		if (reset_n && start_o) begin
			start_count = start_count + 1;
			start_wr    = wr_count;
		end
		we_prev = mem_we_o;
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "stopped by timeout");
		end
	end

	initial begin : stimulus
		int round;
		ioctl_download_i <= 1'b0;
		ioctl_index_i    <= 8'h00;
		ioctl_wr_i       <= 1'b0;
		ioctl_addr_i     <= '0;
		ioctl_data_i     <= '0;
		wait (reset_n);
		@(negedge clk_sys);
		check_value("reset mem_we_o", 0, int'(mem_we_o));
		check_value("reset ioctl_wait_o", 0, int'(ioctl_wait_o));
		check_value("reset start_o", 0, int'(start_o));
		io_enable = 1'b1;
		for (round = 0; round < NUM_ROUNDS; round++) begin
			// Second half runs with slow slots
			if (round >= NUM_ROUNDS / 2) begin
				io_min = 4;
				io_max = 5;
			end
			run_prg(round);
			run_tap(round);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source
// 10 ns clock, synchronous active low reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys_o,
	output logic reset_n_o
);

	localparam int RESET_CYCLES = 2;

	initial begin
		clk_sys_o = 1'b0;
		forever #5 clk_sys_o = !clk_sys_o;
	end

	initial begin
		reset_n_o <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys_o);
		reset_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== logic/basic_ptr_init.sv ====
// BASIC pointer setup after a PRG load
// Walks page zero, writes the pointers a BASIC LOAD would leave, then starts
`timescale 1ns/1ps
`default_nettype none

module basic_ptr_init
	import c64_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  prg_done_i,
	input  logic [15:0]           prg_end_i,
	input  logic                  slot_busy_i,
	output logic                  pi_req_o,
	output logic [MEM_ADDR_W-1:0] pi_addr_o,
	output logic [DATA_W-1:0]     pi_data_o,
	output logic                  start_o
);

	ptr_init_state_e   state;
	logic [8:0]        walk_addr;
	logic [15:0]       end_addr;
	logic              walk_end;
	logic              ptr_hit;
	logic [DATA_W-1:0] ptr_byte;
	logic              step;

	assign walk_end = (walk_addr == PTR_PAGE_END);

	// Skipped addresses advance at once, pointer bytes wait for a free slot
	assign step = (state == SCAN) && !walk_end && (!ptr_hit || !slot_busy_i);

	// ========================================
	// Pointer table
	// ========================================

	always_comb begin
		ptr_hit  = 1'b1;
		ptr_byte = '0;
		case (walk_addr[7:0])
			// Start of BASIC text, as after reset
			8'h2B: ptr_byte = 8'h01;
			8'h2C: ptr_byte = 8'h08;
			// Save start left at zero
			8'hAC, 8'hAD: ptr_byte = 8'h00;
			// VAR, ARY, STR and load end all follow the program end
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_byte = end_addr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_byte = end_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// ========================================
	// Walk FSM
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state    <= IDLE;
			pi_req_o <= 1'b0;
			start_o  <= 1'b0;
		end else begin
			pi_req_o <= 1'b0;
			start_o  <= 1'b0;
			case (state)
				IDLE: begin
					if (prg_done_i)
						state <= SCAN;
				end
				SCAN: begin
					if (walk_end) begin
						start_o <= 1'b1;
						state   <= DONE;
					end else if (ptr_hit && !slot_busy_i) begin
						pi_req_o <= 1'b1;
						state    <= WAIT_SLOT;
					end
				end
				WAIT_SLOT: begin
					// Busy only shows up the cycle after the request
					if (!pi_req_o && !slot_busy_i)
						state <= SCAN;
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Walk position and write payload
	always_ff @(posedge clk_sys) begin
		if ((state == IDLE) && prg_done_i) begin
			walk_addr <= '0;
			end_addr  <= prg_end_i;
		end else if (step) begin
			walk_addr <= walk_addr + 9'd1;
			pi_addr_o <= MEM_ADDR_W'(walk_addr[7:0]);
			pi_data_o <= ptr_byte;
		end
	end

	// ========================================
	// Checks
	// ========================================

	start_single_pulse: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		start_o |=> !start_o
	);

endmodule

`default_nettype wire

// ==== logic/c64_loader_pkg.sv ====
// C64 media loader shared definitions
// Bus widths, download index codes and the pointer walk states
`default_nettype none

package c64_loader_pkg;

	// ========================================
	// Bus widths
	// ========================================

	// Memory address, covers the whole SDRAM window
	localparam int MEM_ADDR_W = 25;

	// Byte address within a host download
	localparam int HOST_ADDR_W = 25;

	localparam int DATA_W = 8;

	// ========================================
	// Download index codes
	// ========================================

	// PRG index in the low six bits, top two bits must be clear
	localparam logic [5:0] IDX_PRG = 6'd4;

	// TAP uses the full index byte
	localparam logic [7:0] IDX_TAP = 8'd6;

	// ========================================
	// BASIC pointer walk
	// ========================================

	// Walk covers page zero and stops here
	localparam logic [8:0] PTR_PAGE_END = 9'h100;

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		WAIT_SLOT,
		DONE
	} ptr_init_state_e;

endpackage

`default_nettype wire

// ==== logic/c64_loader_top.sv ====
// C64 media loader top level
// Connects the download decoder, the pointer walk and the I/O write slot
`timescale 1ns/1ps
`default_nettype none

module c64_loader_top
	import c64_loader_pkg::*;
#(
	parameter logic [MEM_ADDR_W-1:0] TAP_BASE = 25'h200000
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  logic [HOST_ADDR_W-1:0] ioctl_addr_i,
	input  logic [DATA_W-1:0]      ioctl_data_i,
	input  logic                   io_cycle_i,
	output logic                   ioctl_wait_o,
	output logic                   mem_we_o,
	output logic [MEM_ADDR_W-1:0]  mem_addr_o,
	output logic [DATA_W-1:0]      mem_data_o,
	output logic                   start_o
);

	// Decoder requests
	wire                  dl_req;
	wire [MEM_ADDR_W-1:0] dl_addr;
	wire [DATA_W-1:0]     dl_data;

	// Pointer walk requests
	wire                  pi_req;
	wire [MEM_ADDR_W-1:0] pi_addr;
	wire [DATA_W-1:0]     pi_data;

	wire                  prg_done;
	wire [15:0]           prg_end;
	wire                  slot_busy;

	// Host is held off while the slot is full
	assign ioctl_wait_o = slot_busy;

	download_decoder #(
		.TAP_BASE(TAP_BASE)
	) download_decoder_i (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.ioctl_download_i(ioctl_download_i),
		.ioctl_index_i(ioctl_index_i),
		.ioctl_wr_i(ioctl_wr_i),
		.ioctl_addr_i(ioctl_addr_i),
		.ioctl_data_i(ioctl_data_i),
		.dl_req_o(dl_req),
		.dl_addr_o(dl_addr),
		.dl_data_o(dl_data),
		.prg_done_o(prg_done),
		.prg_end_o(prg_end)
	);

	basic_ptr_init basic_ptr_init_i (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.prg_done_i(prg_done),
		.prg_end_i(prg_end),
		.slot_busy_i(slot_busy),
		.pi_req_o(pi_req),
		.pi_addr_o(pi_addr),
		.pi_data_o(pi_data),
		.start_o(start_o)
	);

	io_slot_writer io_slot_writer_i (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dl_req_i(dl_req),
		.dl_addr_i(dl_addr),
		.dl_data_i(dl_data),
		.pi_req_i(pi_req),
		.pi_addr_i(pi_addr),
		.pi_data_i(pi_data),
		.io_cycle_i(io_cycle_i),
		.slot_busy_o(slot_busy),
		.mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o)
	);

endmodule

`default_nettype wire

// ==== logic/download_decoder.sv ====
// Host download decoder
// Turns PRG and TAP bytes into memory write requests and tracks the PRG end
`timescale 1ns/1ps
`default_nettype none

module download_decoder
	import c64_loader_pkg::*;
#(
	parameter logic [MEM_ADDR_W-1:0] TAP_BASE = 25'h200000
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  logic [HOST_ADDR_W-1:0] ioctl_addr_i,
	input  logic [DATA_W-1:0]      ioctl_data_i,
	output logic                   dl_req_o,
	output logic [MEM_ADDR_W-1:0]  dl_addr_o,
	output logic [DATA_W-1:0]      dl_data_o,
	output logic                   prg_done_o,
	output logic [15:0]            prg_end_o
);

	logic                  is_prg;
	logic                  is_tap;
	logic                  host_wr;
	logic                  hdr_lo;
	logic                  hdr_hi;
	logic                  old_download;
	logic [MEM_ADDR_W-1:0] load_addr;

	// ========================================
	// Index and header decode
	// ========================================

	assign is_prg  = (ioctl_index_i[7:6] == 2'b00) && (ioctl_index_i[5:0] == IDX_PRG);
	assign is_tap  = (ioctl_index_i == IDX_TAP);
	assign host_wr = ioctl_wr_i && ioctl_download_i;

	// First two PRG bytes carry the load address
	assign hdr_lo = (ioctl_addr_i == '0);
	assign hdr_hi = (ioctl_addr_i == HOST_ADDR_W'(1));

	// ========================================
	// Request strobe and end of PRG
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_download <= 1'b0;
			dl_req_o     <= 1'b0;
			prg_done_o   <= 1'b0;
		end else begin
			old_download <= ioctl_download_i;

			// Header bytes of a PRG never reach memory
			dl_req_o <= host_wr && ((is_prg && !hdr_lo && !hdr_hi) || is_tap);

			// Download dropped while a PRG was selected
			prg_done_o <= old_download && !ioctl_download_i && is_prg;
		end
	end

	// ========================================
	// Running address and write payload
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (host_wr && is_prg) begin
			if (hdr_lo) begin
				load_addr      <= MEM_ADDR_W'(ioctl_data_i);
				prg_end_o[7:0] <= ioctl_data_i;
			end else if (hdr_hi) begin
				load_addr[15:8] <= ioctl_data_i;
				prg_end_o[15:8] <= ioctl_data_i;
			end else begin
				dl_addr_o <= load_addr;
				dl_data_o <= ioctl_data_i;
				load_addr <= load_addr + MEM_ADDR_W'(1);
				prg_end_o <= prg_end_o + 16'd1;
			end
		end else if (host_wr && is_tap) begin
			dl_data_o <= ioctl_data_i;
			if (hdr_lo) begin
				// Tape image always starts at the base of its region
				dl_addr_o <= TAP_BASE;
				load_addr <= TAP_BASE + MEM_ADDR_W'(1);
			end else begin
				dl_addr_o <= load_addr;
				load_addr <= load_addr + MEM_ADDR_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/io_slot_writer.sv ====
// One-entry memory write slot
// Holds one request from either source and writes it in the next I/O cycle
`timescale 1ns/1ps
`default_nettype none

module io_slot_writer
	import c64_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  dl_req_i,
	input  logic [MEM_ADDR_W-1:0] dl_addr_i,
	input  logic [DATA_W-1:0]     dl_data_i,
	input  logic                  pi_req_i,
	input  logic [MEM_ADDR_W-1:0] pi_addr_i,
	input  logic [DATA_W-1:0]     pi_data_i,
	input  logic                  io_cycle_i,
	output logic                  slot_busy_o,
	output logic                  mem_we_o,
	output logic [MEM_ADDR_W-1:0] mem_addr_o,
	output logic [DATA_W-1:0]     mem_data_o
);

	logic                  pend;
	logic                  io_cycle_d;
	logic                  slot_edge;
	logic                  slot_done;
	logic                  fire;
	logic [MEM_ADDR_W-1:0] hold_addr;
	logic [DATA_W-1:0]     hold_data;

	// ========================================
	// I/O cycle edges
	// ========================================

	// Slot opens when the memory hands the cycle over
	assign slot_edge = !io_cycle_i && io_cycle_d;

	// Two high cycles in a row close the write
	assign slot_done = io_cycle_i && io_cycle_d;

	assign fire = slot_edge && pend;

	// Busy from acceptance until the write is closed
	assign slot_busy_o = pend || mem_we_o;

	// ========================================
	// Slot control
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			pend       <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;

			if (dl_req_i || pi_req_i)
				pend <= 1'b1;
			else if (fire)
				pend <= 1'b0;

			if (fire)
				mem_we_o <= 1'b1;
			else if (slot_done)
				mem_we_o <= 1'b0;
		end
	end

	// ========================================
	// Holding register and memory port
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (dl_req_i) begin
			hold_addr <= dl_addr_i;
			hold_data <= dl_data_i;
		end else if (pi_req_i) begin
			hold_addr <= pi_addr_i;
			hold_data <= pi_data_i;
		end

		if (fire) begin
			mem_addr_o <= hold_addr;
			mem_data_o <= hold_data;
		end
	end

	// ========================================
	// Checks
	// ========================================

	// Sources must respect the busy level or a byte would be lost
	req_while_busy: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		(dl_req_i || pi_req_i) |-> !slot_busy_o
	);

	// Host download and pointer walk never overlap
	req_collision: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		!(dl_req_i && pi_req_i)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the C64 loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f c64_loader_top.f --top-module c64_loader_tb \
	-Mdir obj_dir -o sim_c64_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_c64_loader > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0
